// File: Bender.yml
package:
  name: ks10-cpu

sources:
  - verilog/ks10Pkg.sv
  - verilog/apr.sv
  - verilog/pi.sv
  - verilog/timer.sv
  - verilog/intf.sv
  - verilog/busCycle.sv
  - verilog/cpu.sv
  - target: test
    files:
      - verification/cpuTb.sv

// File: files.f
verilog/ks10Pkg.sv
verilog/apr.sv
verilog/pi.sv
verilog/timer.sv
verilog/intf.sv
verilog/busCycle.sv
verilog/cpu.sv
verification/cpuTb.sv

// File: verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

   localparam vecFile = "verification/cpuTestdata.txt";

   // DUT inputs
   logic                              clk;
   logic                              rstN;
   logic [0:ks10Pkg::cromWidth-1]     crom;
   logic [0:ks10Pkg::wordWidth-1]     dp;
   logic                              cslSet;
   logic                              cslRun;
   logic                              cslCont;
   logic                              cslExec;
   logic                              cslTimerEn;
   logic                              cslIntrI;
   logic [1:ks10Pkg::numLevels]       ubaIntr;
   logic                              busAck;
   logic [0:ks10Pkg::wordWidth-1]     busDataI;

   // DUT outputs
   logic                              cslIntrO;
   logic                              busReq;
   logic                              busBusy;
   logic [0:ks10Pkg::wordWidth-1]     busAddr;
   logic [0:ks10Pkg::wordWidth-1]     busDataO;
   logic [0:ks10Pkg::wordWidth-1]     busData;
   logic                              cpuRun;
   logic                              cpuCont;
   logic                              cpuExec;
   logic                              cpuHalt;
   logic [0:ks10Pkg::aprFlagWidth-1]  aprFlags;
   logic [0:ks10Pkg::priWidth-1]      piReqPri;
   logic [0:ks10Pkg::priWidth-1]      piCurPri;
   logic                              piIntr;

   // Current vector, one line of the data file
   int                                vTest;
   int                                vKind;          // 0 step, 1 bus cycle, 2 timer
   logic [0:ks10Pkg::cromWidth-1]     vCrom;
   logic [0:ks10Pkg::wordWidth-1]     vDp;
   logic [5:0]                        vCsl;           // Set run cont exec timerEn intrI
   logic [1:ks10Pkg::numLevels]       vUba;
   logic [0:ks10Pkg::wordWidth-1]     vDataI;
   logic                              vAck;
   logic [7:0]                        expFlags;
   logic [0:ks10Pkg::priWidth-1]      expReq;
   logic [0:ks10Pkg::priWidth-1]      expCur;
   logic [7:0]                        expStat;
   logic                              vChkW;          // Bus words valid to compare
   logic [0:ks10Pkg::wordWidth-1]     expAddr;
   logic [0:ks10Pkg::wordWidth-1]     expDataO;
   logic [0:ks10Pkg::wordWidth-1]     expData;

   int                                errors = 0;
   int                                tests = 0;
   int                                failedTests = 0;
   logic                              testBad;

   cpu UUT (.*);

   always #50 clk = ~clk;                             // 100 ns period

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic checkWord(input string name, input logic [0:ks10Pkg::wordWidth-1] act,
                            input logic [0:ks10Pkg::wordWidth-1] exp);
      if (act !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, act, exp);
         errors++;
         testBad = 1'b1;
      end
   endtask

   task automatic checkPri(input string name, input logic [0:ks10Pkg::priWidth-1] act,
                           input logic [0:ks10Pkg::priWidth-1] exp);
      if (act !== exp) begin
         $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
         errors++;
         testBad = 1'b1;
      end
   endtask

   task automatic checkBits(input string name, input logic [7:0] act, input logic [7:0] exp);
      if (act !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, act, exp);
         errors++;
         testBad = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Drive and wait
   //////////////////////////////////////////////////////////////////////

   task automatic driveVector();
      crom     = vCrom;
      dp       = vDp;
      {cslSet, cslRun, cslCont, cslExec, cslTimerEn, cslIntrI} = vCsl;
      ubaIntr  = vUba;
      busDataI = vDataI;
      busAck   = 1'b0;
   endtask

   // Ack after a random delay, or never for an NXM cycle
   task automatic waitBusIdle(input int limit, input logic ackIt);
      int n;
      int delay;
      n     = 0;
      delay = $urandom % 7;                           // Always short of the timeout
      while (busReq && n < limit) begin
         if (ackIt && n >= delay)
            busAck = 1'b1;
         @(negedge clk);
         n++;
      end
      busAck = 1'b0;
      if (busReq) begin
         $display("Bus request still high after %0d cycles in test %0d", limit, vTest);
         errors++;
         testBad = 1'b1;
      end
   endtask

   task automatic waitFlag(input int idx, input int limit);
      int n;
      n = 0;
      while (!aprFlags[idx] && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!aprFlags[idx]) begin
         $display("APR flag %0d never set within %0d cycles in test %0d", idx, limit, vTest);
         errors++;
         testBad = 1'b1;
      end
   endtask

   task automatic runVector();
      testBad = 1'b0;
      driveVector();
      case (vKind)
         0: begin                                     // Order for one clock, then settle
            @(negedge clk);
            crom = '0;
            @(negedge clk);
         end
         1: begin
            @(negedge clk);
            crom = '0;
            waitBusIdle(ks10Pkg::nxmTimeout + 2, vAck);
            repeat (2) @(negedge clk);                // Flag then PI latency
         end
         2: waitFlag(ks10Pkg::aprIntDone, ks10Pkg::timerPeriod + 3);
         default: begin
            $display("Unknown vector kind %0d in test %0d", vKind, vTest);
            errors++;
            testBad = 1'b1;
         end
      endcase
      checkBits("aprFlags", 8'(aprFlags), expFlags);
      checkPri("piReqPri", piReqPri, expReq);
      checkPri("piCurPri", piCurPri, expCur);
      checkBits("status", {busBusy, piIntr, cslIntrO, busReq,
                           cpuRun, cpuCont, cpuExec, cpuHalt}, expStat);
      if (vChkW) begin
         checkWord("busAddr", busAddr, expAddr);
         checkWord("busDataO", busDataO, expDataO);
         checkWord("busData", busData, expData);
      end
      tests++;
      if (testBad)
         failedTests++;
      $display("Test %0d kind %0d: %s", vTest, vKind, testBad ? "FAIL" : "ok");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int    fd;
      int    n;
      int    seedVal;
      string line;
      seedVal = $urandom(32'h080a9e83);
      clk     = 1'b0;
      rstN    = 1'b0;
      vTest   = 0;
      vCrom   = '0;
      vDp     = '0;
      vCsl    = '0;
      vUba    = '0;
      vDataI  = '0;
      driveVector();                                  // All inputs quiet
      repeat (16) @(negedge clk);
      rstN = 1'b1;

      fd = $fopen(vecFile, "r");
      if (fd == 0) begin
         $display("Cannot open vector file %s", vecFile);
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 1) == "//")
               continue;                              // Blank or column notes
            n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vTest, vKind, vCrom, vDp, vCsl, vUba, vDataI, vAck,
                        expFlags, expReq, expCur, expStat, vChkW, expAddr, expDataO, expData);
            if (n != 16) begin
               $display("Malformed vector line: %s", line);
               errors++;
               continue;
            end
            runVector();
         end
         $fclose(fd);
      end

      $display("Tests %0d, failed %0d, check errors %0d", tests, failedTests, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: verification/cpuTestdata.txt
// test kind crom dp csl uba dataI ack | flags req cur stat chkW busAddr busDataO busData
// csl = set run cont exec timerEn intrI, stat = busy piIntr cslIntrO req run cont exec halt
1 0 000 000000000 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
2 0 000 000000000 3c 00 000000000 0 00 0 0 0e 0 000000000 000000000 000000000
3 0 420 000000000 00 00 000000000 0 00 0 0 07 0 000000000 000000000 000000000
4 0 440 000000000 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
5 0 120 000000007 00 00 000000000 0 07 0 0 21 0 000000000 000000000 000000000
6 0 140 000000004 00 00 000000000 0 03 0 0 01 0 000000000 000000000 000000000
7 0 000 000000000 01 00 000000000 0 0b 0 0 01 0 000000000 000000000 000000000
8 0 140 00000000b 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
9 0 2ff 000000000 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
10 0 16c 000000002 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
11 0 000 000000000 00 06 000000000 0 00 5 0 41 0 000000000 000000000 000000000
12 0 120 000000002 00 06 000000000 0 02 3 0 41 0 000000000 000000000 000000000
13 0 320 000000000 00 06 000000000 0 02 3 3 01 0 000000000 000000000 000000000
14 0 000 000000000 00 46 000000000 0 02 1 3 41 0 000000000 000000000 000000000
15 0 320 000000000 00 46 000000000 0 02 1 1 01 0 000000000 000000000 000000000
16 0 340 000000000 00 06 000000000 0 02 3 3 01 0 000000000 000000000 000000000
17 0 340 000000000 00 06 000000000 0 02 3 0 41 0 000000000 000000000 000000000
18 0 284 000000000 00 06 000000000 0 02 5 0 41 0 000000000 000000000 000000000
19 0 360 000000000 00 06 000000000 0 02 0 0 01 0 000000000 000000000 000000000
20 0 140 000000002 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
21 0 520 123456789 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
22 1 560 000000200 00 00 0abcdef01 1 00 0 0 01 1 000000200 123456789 0abcdef01
23 1 540 000001000 00 00 000000000 1 00 0 0 01 1 000001000 123456789 0abcdef01
24 0 560 000003000 00 00 555555555 0 00 0 0 91 1 000003000 123456789 0abcdef01
25 0 540 000007000 00 00 555555555 0 00 0 0 91 1 000003000 123456789 0abcdef01
26 1 000 000000000 00 00 555555555 1 00 0 0 01 1 000003000 123456789 555555555
27 0 168 000000020 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
28 0 2a0 000000000 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
29 1 560 000077000 00 00 000000000 0 20 2 0 41 1 000077000 123456789 555555555
30 0 140 000000020 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
31 2 000 000000000 02 00 000000000 0 10 0 0 01 0 000000000 000000000 000000000
32 0 140 000000010 02 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000
33 2 000 000000000 02 00 000000000 0 10 0 0 01 0 000000000 000000000 000000000
34 0 140 000000010 00 00 000000000 0 00 0 0 01 0 000000000 000000000 000000000

// File: verilog/apr.sv
`timescale 1ns/1ps

module apr (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic [0:ks10Pkg::cromWidth-1]       crom,       // Control word
   input  logic [0:ks10Pkg::wordWidth-1]       dp,         // Datapath bus
   input  logic                                timerIntr,  // Interval timer wrap
   input  logic                                nxmIntr,    // Bus timeout
   input  logic                                cslIntr,    // Console interrupt in
   output logic [0:ks10Pkg::aprFlagWidth-1]    aprFlags,
   output logic [1:ks10Pkg::numLevels]         aprIntr     // One-hot request
);

   ks10Pkg::specU                       spec;
   logic                                aprSel;
   logic [0:ks10Pkg::aprFlagWidth-1]    flagMask;
   logic [0:ks10Pkg::aprFlagWidth-1]    flagsNext;
   logic [0:ks10Pkg::aprFlagWidth-1]    aprEnable;   // Flag interrupt enables
   logic [0:ks10Pkg::priWidth-1]        aprLevel;    // Request level, 0 is off
   logic                                aprActive;

   assign spec     = crom[ks10Pkg::cromSpec +: ks10Pkg::specWidth];
   assign aprSel   = crom[ks10Pkg::cromDest +: ks10Pkg::destWidth] == ks10Pkg::destApr;
   assign flagMask = dp[ks10Pkg::aprDpBase +: ks10Pkg::aprFlagWidth];  // dp 30..35

   // Microcode set/clear first, then hardware events win
   always_comb begin
      flagsNext = aprFlags;
      if (aprSel && spec.opView.op == ks10Pkg::aprSetFlags)
         flagsNext = flagsNext | flagMask;
      if (aprSel && spec.opView.op == ks10Pkg::aprClrFlags)
         flagsNext = flagsNext & ~flagMask;
      if (nxmIntr)
         flagsNext[ks10Pkg::aprNxm] = 1'b1;
      if (timerIntr)
         flagsNext[ks10Pkg::aprIntDone] = 1'b1;
      if (cslIntr)
         flagsNext[ks10Pkg::aprCslIn] = 1'b1;        // Level input, sets every edge
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         aprFlags  <= '0;
         aprEnable <= '0;
         aprLevel  <= '0;
      end else begin
         aprFlags <= flagsNext;
         if (aprSel && spec.opView.op == ks10Pkg::aprLoadEn) begin
            aprEnable <= flagMask;
            aprLevel  <= spec.opView.level;
         end
      end
   end

   // Any enabled flag raises a request on the stored level
   assign aprActive = |(aprFlags & aprEnable);

   always_comb begin
      aprIntr = '0;
      for (int i = 1; i <= ks10Pkg::numLevels; i++)
         aprIntr[i] = aprActive && (aprLevel == i);
   end

endmodule

// File: verilog/busCycle.sv
`timescale 1ns/1ps

module busCycle (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [0:ks10Pkg::cromWidth-1]   crom,
   input  logic [0:ks10Pkg::wordWidth-1]   dp,
   input  logic                            busAck,     // Acknowledge from memory/IO
   input  logic [0:ks10Pkg::wordWidth-1]   busDataI,
   output logic                            busReq,     // Held until ack or timeout
   output logic                            busBusy,
   output logic [0:ks10Pkg::wordWidth-1]   busAddr,
   output logic [0:ks10Pkg::wordWidth-1]   busDataO,
   output logic [0:ks10Pkg::wordWidth-1]   busData,    // Captured read data
   output logic                            nxmIntr     // Timeout pulse
);

   ks10Pkg::specU                   spec;
   logic                            busSel;
   logic                            startCycle;
   logic                            cycleState;
   logic                            cycleRead;     // Current cycle is a read
   logic [ks10Pkg::nxmWidth-1:0]    toCount;       // Clocks waited for ack

   assign spec       = crom[ks10Pkg::cromSpec +: ks10Pkg::specWidth];
   assign busSel     = crom[ks10Pkg::cromDest +: ks10Pkg::destWidth] == ks10Pkg::destBus;
   assign busReq     = cycleState == ks10Pkg::busWait;
   assign busBusy    = busReq;
   assign startCycle = busSel && !busReq && (spec.opView.op == ks10Pkg::busWrite ||
                                             spec.opView.op == ks10Pkg::busRead);

   //////////////////////////////////////////////////////////////////////
   // Request sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         cycleState <= ks10Pkg::busIdle;
         cycleRead  <= 1'b0;
         toCount    <= '0;
         nxmIntr    <= 1'b0;
      end else begin
         nxmIntr <= 1'b0;
         case (cycleState)
            ks10Pkg::busIdle:
               if (startCycle) begin              // Start is dropped while busy
                  cycleState <= ks10Pkg::busWait;
                  cycleRead  <= spec.opView.op == ks10Pkg::busRead;
                  toCount    <= '0;
               end
            ks10Pkg::busWait:
               if (busAck)
                  cycleState <= ks10Pkg::busIdle;
               else if (toCount == ks10Pkg::nxmTimeout - 1) begin
                  cycleState <= ks10Pkg::busIdle;  // Nobody answered
                  nxmIntr    <= 1'b1;
               end else
                  toCount <= toCount + 1'b1;
         endcase
      end
   end

   // Address and data words
   always_ff @(posedge clk) begin
      if (startCycle)
         busAddr <= dp;
      if (busSel && spec.opView.op == ks10Pkg::busLoadData)
         busDataO <= dp;
      if (busReq && busAck && cycleRead)
         busData <= busDataI;
   end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic [0:ks10Pkg::cromWidth-1]     crom,        // Control word
   input  logic [0:ks10Pkg::wordWidth-1]     dp,          // Datapath bus
   // Console
   input  logic                              cslSet,      // Load run/cont/exec
   input  logic                              cslRun,
   input  logic                              cslCont,
   input  logic                              cslExec,
   input  logic                              cslTimerEn,
   input  logic                              cslIntrI,    // Console to CPU
   output logic                              cslIntrO,    // CPU to console
   // Unibus
   input  logic [1:ks10Pkg::numLevels]       ubaIntr,
   // Memory/IO bus
   input  logic                              busAck,
   input  logic [0:ks10Pkg::wordWidth-1]     busDataI,
   output logic                              busReq,
   output logic                              busBusy,
   output logic [0:ks10Pkg::wordWidth-1]     busAddr,
   output logic [0:ks10Pkg::wordWidth-1]     busDataO,
   output logic [0:ks10Pkg::wordWidth-1]     busData,
   // Status
   output logic                              cpuRun,
   output logic                              cpuCont,
   output logic                              cpuExec,
   output logic                              cpuHalt,
   output logic [0:ks10Pkg::aprFlagWidth-1]  aprFlags,
   output logic [0:ks10Pkg::priWidth-1]      piReqPri,
   output logic [0:ks10Pkg::priWidth-1]      piCurPri,
   output logic                              piIntr
);

   logic [1:ks10Pkg::numLevels] aprIntr;     // APR request to PI
   logic                        timerIntr;   // Interval timer wrap
   logic                        nxmIntr;     // Bus timeout

   //////////////////////////////////////////////////////////////////////
   // Flags and interrupts
   //////////////////////////////////////////////////////////////////////

   apr uApr (
      .clk       (clk),
      .rstN      (rstN),
      .crom      (crom),
      .dp        (dp),
      .timerIntr (timerIntr),
      .nxmIntr   (nxmIntr),
      .cslIntr   (cslIntrI),
      .aprFlags  (aprFlags),
      .aprIntr   (aprIntr)
   );

   pi uPi (
      .clk       (clk),
      .rstN      (rstN),
      .crom      (crom),
      .aprIntr   (aprIntr),
      .ubaIntr   (ubaIntr),
      .piReqPri  (piReqPri),
      .piCurPri  (piCurPri),
      .piIntr    (piIntr)
   );

   timer uTimer (
      .clk       (clk),
      .rstN      (rstN),
      .timerEn   (cslTimerEn),
      .timerIntr (timerIntr)
   );

   //////////////////////////////////////////////////////////////////////
   // Console and bus
   //////////////////////////////////////////////////////////////////////

   intf uIntf (
      .clk       (clk),
      .rstN      (rstN),
      .crom      (crom),
      .cslSet    (cslSet),
      .cslRun    (cslRun),
      .cslCont   (cslCont),
      .cslExec   (cslExec),
      .cpuRun    (cpuRun),
      .cpuCont   (cpuCont),
      .cpuExec   (cpuExec),
      .cpuHalt   (cpuHalt)
   );

   busCycle uBusCycle (
      .clk       (clk),
      .rstN      (rstN),
      .crom      (crom),
      .dp        (dp),
      .busAck    (busAck),
      .busDataI  (busDataI),
      .busReq    (busReq),
      .busBusy   (busBusy),
      .busAddr   (busAddr),
      .busDataO  (busDataO),
      .busData   (busData),
      .nxmIntr   (nxmIntr)
   );

   // Interrupt to console follows its APR flag
   assign cslIntrO = aprFlags[ks10Pkg::aprCslOut];

endmodule

// File: verilog/intf.sv
`timescale 1ns/1ps

module intf (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [0:ks10Pkg::cromWidth-1]   crom,
   input  logic                            cslSet,     // Load run/cont/exec
   input  logic                            cslRun,
   input  logic                            cslCont,
   input  logic                            cslExec,
   output logic                            cpuRun,
   output logic                            cpuCont,
   output logic                            cpuExec,
   output logic                            cpuHalt
);

   ks10Pkg::specU spec;
   logic          intfSel;

   assign spec    = crom[ks10Pkg::cromSpec +: ks10Pkg::specWidth];
   assign intfSel = crom[ks10Pkg::cromDest +: ks10Pkg::destWidth] == ks10Pkg::destIntf;

   // Console status bits
   // Microcode orders take effect after a console load in the same clock
   always_ff @(posedge clk) begin
      if (!rstN) begin
         cpuRun  <= 1'b0;
         cpuCont <= 1'b0;
         cpuExec <= 1'b0;
         cpuHalt <= 1'b1;                    // Come up halted
      end else begin
         if (cslSet) begin
            cpuRun  <= cslRun;
            cpuCont <= cslCont;
            cpuExec <= cslExec;
            if (cslRun)
               cpuHalt <= 1'b0;
         end
         if (intfSel && spec.opView.op == ks10Pkg::intfHalt) begin
            cpuRun  <= 1'b0;
            cpuHalt <= 1'b1;
         end
         if (intfSel && spec.opView.op == ks10Pkg::intfAck) begin
            cpuCont <= 1'b0;                 // Console request taken
            cpuExec <= 1'b0;
         end
      end
   end

endmodule

// File: verilog/ks10Pkg.sv
package ks10Pkg;

   //////////////////////////////////////////////////////////////////////
   // Word and priority sizes
   //////////////////////////////////////////////////////////////////////

   localparam int wordWidth = 36;            // Bit 0 is the MSB, as on the KS10
   localparam int priWidth  = 3;             // Priority number, 0 means none
   localparam int numLevels = 7;             // PI levels 1 (highest) to 7

   //////////////////////////////////////////////////////////////////////
   // Control ROM word
   //////////////////////////////////////////////////////////////////////

   localparam int cromWidth = 11;
   localparam int cromDest  = 0;             // Destination starts at bit 0
   localparam int destWidth = 3;
   localparam int cromSpec  = 3;             // Special field, bits 3 to 10
   localparam int specWidth = 8;
   localparam int opWidth   = 3;

   // Destinations
   localparam logic [0:destWidth-1] destNone   = 3'd0;
   localparam logic [0:destWidth-1] destApr    = 3'd1;
   localparam logic [0:destWidth-1] destPiLoad = 3'd2;   // Spec is a level mask
   localparam logic [0:destWidth-1] destPiCtl  = 3'd3;
   localparam logic [0:destWidth-1] destIntf   = 3'd4;
   localparam logic [0:destWidth-1] destBus    = 3'd5;

   // Operations, meaning depends on destination
   localparam logic [0:opWidth-1] aprSetFlags = 3'd1;
   localparam logic [0:opWidth-1] aprClrFlags = 3'd2;
   localparam logic [0:opWidth-1] aprLoadEn   = 3'd3;    // Also loads the level
   localparam logic [0:opWidth-1] piGrant     = 3'd1;
   localparam logic [0:opWidth-1] piDismiss   = 3'd2;
   localparam logic [0:opWidth-1] piOff       = 3'd3;
   localparam logic [0:opWidth-1] intfHalt    = 3'd1;
   localparam logic [0:opWidth-1] intfAck     = 3'd2;
   localparam logic [0:opWidth-1] busLoadData = 3'd1;
   localparam logic [0:opWidth-1] busWrite    = 3'd2;
   localparam logic [0:opWidth-1] busRead     = 3'd3;

   // Special field, two decodings of the same eight bits
   typedef union packed {
      struct packed {
         logic [0:opWidth-1]  op;            // Operation code
         logic [0:priWidth-1] level;         // PI level
         logic [0:1]          spare;
      } opView;
      struct packed {
         logic                sysOn;         // PI system on
         logic [1:numLevels]  levelEn;       // Level enables
      } maskView;
   } specU;

   //////////////////////////////////////////////////////////////////////
   // APR flags, taken from dp bits 30 to 35
   //////////////////////////////////////////////////////////////////////

   localparam int aprFlagWidth = 6;
   localparam int aprDpBase    = wordWidth - aprFlagWidth;
   localparam int aprNxm       = 0;          // Non-existent memory
   localparam int aprIntDone   = 1;          // Interval done
   localparam int aprCslIn     = 2;          // Console interrupt in
   localparam int aprCslOut    = 3;          // Console interrupt out
   localparam int aprSw0       = 4;
   localparam int aprSw1       = 5;

   // Timer and bus timeout
   localparam int timerPeriod = 20;          // Clocks per interval
   localparam int timerWidth  = $clog2(timerPeriod);
   localparam int nxmTimeout  = 12;          // Clocks to wait for an ack
   localparam int nxmWidth    = $clog2(nxmTimeout);

   // Bus sequencer states
   localparam logic busIdle = 1'b0;
   localparam logic busWait = 1'b1;

endpackage

// File: verilog/pi.sv
`timescale 1ns/1ps

module pi (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic [0:ks10Pkg::cromWidth-1]     crom,
   input  logic [1:ks10Pkg::numLevels]       aprIntr,    // APR request
   input  logic [1:ks10Pkg::numLevels]       ubaIntr,    // Unibus requests
   output logic [0:ks10Pkg::priWidth-1]      piReqPri,   // Highest pending level
   output logic [0:ks10Pkg::priWidth-1]      piCurPri,   // Highest level in progress
   output logic                              piIntr
);

   ks10Pkg::specU                      spec;
   logic [0:ks10Pkg::destWidth-1]      dest;
   logic                               sysOn;
   logic                               sysOnNext;
   logic [1:ks10Pkg::numLevels]        levelEn;
   logic [1:ks10Pkg::numLevels]        levelEnNext;
   logic [1:ks10Pkg::numLevels]        inProg;       // Levels being serviced
   logic [1:ks10Pkg::numLevels]        inProgNext;
   logic [1:ks10Pkg::numLevels]        pending;
   logic [0:ks10Pkg::priWidth-1]       reqNext;
   logic [0:ks10Pkg::priWidth-1]       curNext;

   // Lowest set level number wins, 0 if none
   function automatic logic [0:ks10Pkg::priWidth-1] firstLevel(
      input logic [1:ks10Pkg::numLevels] v);
      logic [0:ks10Pkg::priWidth-1] lvl;
      lvl = '0;
      for (int i = ks10Pkg::numLevels; i >= 1; i--)
         if (v[i])
            lvl = ks10Pkg::priWidth'(i);
      return lvl;
   endfunction

   assign spec = crom[ks10Pkg::cromSpec +: ks10Pkg::specWidth];
   assign dest = crom[ks10Pkg::cromDest +: ks10Pkg::destWidth];

   always_comb begin
      sysOnNext   = sysOn;
      levelEnNext = levelEn;
      inProgNext  = inProg;
      if (dest == ks10Pkg::destPiLoad) begin                // Mask decoding
         sysOnNext   = spec.maskView.sysOn;
         levelEnNext = spec.maskView.levelEn;
      end
      if (dest == ks10Pkg::destPiCtl) begin                 // Op decoding
         case (spec.opView.op)
            ks10Pkg::piGrant:
               if (piReqPri != '0)
                  inProgNext[piReqPri] = 1'b1;
            ks10Pkg::piDismiss:
               if (piCurPri != '0)
                  inProgNext[piCurPri] = 1'b0;
            ks10Pkg::piOff:
               sysOnNext = 1'b0;
            default: ;
         endcase
      end
   end

   assign pending = (aprIntr | ubaIntr) & levelEnNext & {ks10Pkg::numLevels{sysOnNext}};
   assign reqNext = firstLevel(pending);
   assign curNext = firstLevel(inProgNext);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         sysOn    <= 1'b0;
         levelEn  <= '0;
         inProg   <= '0;
         piReqPri <= '0;
         piCurPri <= '0;
         piIntr   <= 1'b0;
      end else begin
         sysOn    <= sysOnNext;
         levelEn  <= levelEnNext;
         inProg   <= inProgNext;
         piReqPri <= reqNext;
         piCurPri <= curNext;
         piIntr   <= (reqNext != '0) && (curNext == '0 || reqNext < curNext);
      end
   end

endmodule

// File: verilog/timer.sv
`timescale 1ns/1ps

module timer (
   input  logic clk,
   input  logic rstN,
   input  logic timerEn,      // Console timer enable
   output logic timerIntr     // One clock per period
);

   logic [ks10Pkg::timerWidth-1:0] count;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         count     <= '0;
         timerIntr <= 1'b0;
      end else if (!timerEn) begin
         count     <= '0;                   // Hold at zero
         timerIntr <= 1'b0;
      end else if (count == ks10Pkg::timerPeriod - 1) begin
         count     <= '0;                   // Wrap
         timerIntr <= 1'b1;
      end else begin
         count     <= count + 1'b1;
         timerIntr <= 1'b0;
      end
   end

endmodule
